// ==== common/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// address and data geometry
	localparam int addr_w = 64;
	localparam int word_w = 64;
	localparam int mask_w = 8;

	// a 32-byte line of four words
	localparam int line_words = 4;
	localparam int word_sel_w = 2;
	localparam int byte_off_w = 3;
	localparam int line_off_w = word_sel_w + byte_off_w; // 5 bits below the index

	typedef logic [word_sel_w-1:0] word_sel_t;
	typedef logic [word_w-1:0] word_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

	localparam int burst_len = 4; // beats per line

	// one bit wider than a word index so it can reach burst_len
	typedef logic [2:0] beat_cnt_t;

	typedef enum logic [2:0] {
		idle,
		lookup,
		write_back,
		refill_req,
		refill_wait,
		finish
	} ctrl_state_t;

endpackage

// ==== dcache/cache_way.sv ====
`timescale 1ns/1ps

module cache_way import cache_cfg_pkg::*; #(
	parameter int sets = 64,
	localparam int idx_w = $clog2(sets),
	localparam int tag_w = addr_w - idx_w - line_off_w
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [idx_w-1:0]  index,
	input  logic [tag_w-1:0]  tag,
	input  word_sel_t         word_sel,
	output logic              hit,
	output logic              line_valid,
	output logic              line_dirty,
	output logic [tag_w-1:0]  line_tag,
	output word_t             rd_word,
	input  logic              store_en,
	input  word_t             store_data,
	input  logic [mask_w-1:0] store_mask,
	input  logic              fill_en,
	input  word_sel_t         fill_word,
	input  word_t             fill_data,
	input  logic              install_en
);

	logic [sets-1:0] valid_q;
	logic [sets-1:0] dirty_q;
	logic [tag_w-1:0] tag_q [sets];
	word_t data_q [sets][line_words];

	// lookup is purely combinational
	assign line_valid = valid_q[index];
	assign line_dirty = dirty_q[index];
	assign line_tag   = tag_q[index];
	assign hit        = valid_q[index] && (tag_q[index] == tag);
	assign rd_word    = data_q[index][word_sel]; // load data and write-back beats

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (install_en)
				valid_q[index] <= 1'b1;
			// a store in the install cycle leaves the line dirty
			if (store_en)
				dirty_q[index] <= 1'b1;
			else if (install_en)
				dirty_q[index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (install_en)
			tag_q[index] <= tag;
	end

	// refill beats and masked store merge
	always_ff @(posedge clk) begin
		if (fill_en) begin
			data_q[index][fill_word] <= fill_data;
		end else if (store_en) begin
			for (int b = 0; b < mask_w; b++) begin
				if (store_mask[b])
					data_q[index][word_sel][b*8 +: 8] <= store_data[b*8 +: 8];
			end
		end
	end

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl import cache_cfg_pkg::*, mem_bus_pkg::*; #(
	parameter int sets = 64,
	localparam int idx_w = $clog2(sets),
	localparam int tag_w = addr_w - idx_w - line_off_w
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  logic              req_write,
	input  logic [addr_w-1:0] req_addr,
	input  word_t             req_wdata,
	input  logic [mask_w-1:0] req_wmask,
	output logic              req_ready,
	output word_t             rsp_rdata,
	output logic              mem_req_valid,
	output logic              mem_req_write,
	output logic [addr_w-1:0] mem_req_addr,
	output word_t             mem_wdata,
	input  logic              mem_ready,
	input  logic              mem_rvalid,
	input  word_t             mem_rdata,
	input  logic              hit_0,
	input  logic              line_valid_0,
	input  logic              line_dirty_0,
	input  logic [tag_w-1:0]  line_tag_0,
	input  word_t             rd_word_0,
	input  logic              hit_1,
	input  logic              line_valid_1,
	input  logic              line_dirty_1,
	input  logic [tag_w-1:0]  line_tag_1,
	input  word_t             rd_word_1,
	output logic [idx_w-1:0]  way_index,
	output logic [tag_w-1:0]  way_tag,
	output word_sel_t         way_word_sel,
	output logic              store_en_0,
	output logic              store_en_1,
	output logic              fill_en_0,
	output logic              fill_en_1,
	output logic              install_en_0,
	output logic              install_en_1,
	output word_sel_t         fill_word,
	output word_t             fill_data,
	output word_t             store_data,
	output logic [mask_w-1:0] store_mask
);

	localparam beat_cnt_t last_beat = beat_cnt_t'(burst_len - 1);

	ctrl_state_t state, state_nxt;

	logic [addr_w-1:0] addr_q;
	logic write_q;
	word_t wdata_q;
	logic [mask_w-1:0] wmask_q;

	logic [sets-1:0] lru_q; // 1 means way 1 is least recently used
	logic victim_q;
	beat_cnt_t wb_cnt;
	beat_cnt_t req_cnt;
	beat_cnt_t rsp_cnt;

	logic [idx_w-1:0] req_idx;
	logic [tag_w-1:0] req_tag;
	word_sel_t req_word;
	logic any_hit;
	logic victim_nxt;
	logic victim_dirty;
	logic [tag_w-1:0] victim_tag;
	logic sel_way;
	logic wb_beat;
	logic rd_beat;
	logic fill_beat;

	assign req_idx  = addr_q[line_off_w +: idx_w];
	assign req_tag  = addr_q[addr_w-1 -: tag_w];
	assign req_word = addr_q[byte_off_w +: word_sel_w];
	assign any_hit  = hit_0 || hit_1;

	// invalid way first, otherwise the LRU way
	always_comb begin
		if (!line_valid_0)
			victim_nxt = 1'b0;
		else if (!line_valid_1)
			victim_nxt = 1'b1;
		else
			victim_nxt = lru_q[req_idx];
	end

	assign victim_dirty = victim_nxt ? line_dirty_1 : line_dirty_0;
	assign victim_tag   = victim_q ? line_tag_1 : line_tag_0;

	assign wb_beat   = (state == write_back) && mem_ready;
	assign rd_beat   = (state == refill_req) && mem_ready;
	assign fill_beat = mem_rvalid && (state == refill_req || state == refill_wait);

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (req_valid)
					state_nxt = lookup;
			end
			lookup: begin
				if (any_hit)
					state_nxt = idle;
				else if (victim_dirty)
					state_nxt = write_back;
				else
					state_nxt = refill_req;
			end
			write_back: begin
				if (wb_beat && wb_cnt == last_beat)
					state_nxt = refill_req;
			end
			refill_req: begin
				if (rd_beat && req_cnt == last_beat)
					state_nxt = refill_wait;
			end
			refill_wait: begin
				if (mem_rvalid && rsp_cnt == last_beat) // last return beat
					state_nxt = finish;
			end
			finish: state_nxt = idle;
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= idle;
			lru_q    <= '0;
			victim_q <= 1'b0;
			wb_cnt   <= '0;
			req_cnt  <= '0;
			rsp_cnt  <= '0;
		end else begin
			state <= state_nxt;
			if (state == lookup) begin
				victim_q <= victim_nxt;
				wb_cnt   <= '0;
				req_cnt  <= '0;
				rsp_cnt  <= '0;
				if (any_hit)
					lru_q[req_idx] <= hit_0; // the other way becomes LRU
			end
			if (wb_beat)
				wb_cnt <= wb_cnt + beat_cnt_t'(1);
			if (rd_beat)
				req_cnt <= req_cnt + beat_cnt_t'(1);
			if (fill_beat)
				rsp_cnt <= rsp_cnt + beat_cnt_t'(1);
			if (state == finish)
				lru_q[req_idx] <= ~victim_q;
		end
	end

	// request held here for the whole miss
	always_ff @(posedge clk) begin
		if (state == idle && req_valid) begin
			addr_q  <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
			wmask_q <= req_wmask;
		end
	end

	assign way_index    = req_idx;
	assign way_tag      = req_tag;
	assign way_word_sel = (state == write_back) ? wb_cnt[word_sel_w-1:0] : req_word;

	assign store_en_0   = write_q && ((state == lookup && hit_0) || (state == finish && !victim_q));
	assign store_en_1   = write_q && ((state == lookup && hit_1) || (state == finish && victim_q));
	assign fill_en_0    = fill_beat && !victim_q;
	assign fill_en_1    = fill_beat && victim_q;
	assign install_en_0 = (state == finish) && !victim_q;
	assign install_en_1 = (state == finish) && victim_q;
	assign fill_word    = rsp_cnt[word_sel_w-1:0]; // beats return in order
	assign fill_data    = mem_rdata;
	assign store_data   = wdata_q;
	assign store_mask   = wmask_q;

	assign mem_req_valid = (state == write_back) || (state == refill_req);
	assign mem_req_write = (state == write_back);
	assign mem_wdata     = victim_q ? rd_word_1 : rd_word_0;

	always_comb begin
		if (state == write_back)
			mem_req_addr = {victim_tag, req_idx, wb_cnt[word_sel_w-1:0], {byte_off_w{1'b0}}};
		else
			mem_req_addr = {req_tag, req_idx, req_cnt[word_sel_w-1:0], {byte_off_w{1'b0}}};
	end

	// hit way in lookup, filled victim in finish
	assign sel_way   = (state == finish) ? victim_q : hit_1;
	assign rsp_rdata = sel_way ? rd_word_1 : rd_word_0;
	assign req_ready = (state == lookup && any_hit) || (state == finish);

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import cache_cfg_pkg::*; #(
	parameter int sets = 64,
	localparam int idx_w = $clog2(sets),
	localparam int tag_w = addr_w - idx_w - line_off_w
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  logic              req_write,
	input  logic [addr_w-1:0] req_addr,
	input  word_t             req_wdata,
	input  logic [mask_w-1:0] req_wmask,
	output logic              req_ready,
	output word_t             rsp_rdata,
	output logic              mem_req_valid,
	output logic              mem_req_write,
	output logic [addr_w-1:0] mem_req_addr,
	output word_t             mem_wdata,
	input  logic              mem_ready,
	input  logic              mem_rvalid,
	input  word_t             mem_rdata
);

	logic hit_0, line_valid_0, line_dirty_0, hit_1, line_valid_1, line_dirty_1;
	logic [tag_w-1:0] line_tag_0, line_tag_1, way_tag;
	word_t rd_word_0, rd_word_1, fill_data, store_data;
	logic [idx_w-1:0] way_index;
	word_sel_t way_word_sel, fill_word;
	logic store_en_0, store_en_1, fill_en_0, fill_en_1, install_en_0, install_en_1;
	logic [mask_w-1:0] store_mask;

	cache_way #(.sets(sets)) way0_i (
		.clk(clk), .rst_n(rst_n), .index(way_index), .tag(way_tag), .word_sel(way_word_sel),
		.hit(hit_0), .line_valid(line_valid_0), .line_dirty(line_dirty_0),
		.line_tag(line_tag_0), .rd_word(rd_word_0), .store_en(store_en_0),
		.store_data(store_data), .store_mask(store_mask), .fill_en(fill_en_0),
		.fill_word(fill_word), .fill_data(fill_data), .install_en(install_en_0)
	);

	cache_way #(.sets(sets)) way1_i (
		.clk(clk), .rst_n(rst_n), .index(way_index), .tag(way_tag), .word_sel(way_word_sel),
		.hit(hit_1), .line_valid(line_valid_1), .line_dirty(line_dirty_1),
		.line_tag(line_tag_1), .rd_word(rd_word_1), .store_en(store_en_1),
		.store_data(store_data), .store_mask(store_mask), .fill_en(fill_en_1),
		.fill_word(fill_word), .fill_data(fill_data), .install_en(install_en_1)
	);

	dcache_ctrl #(.sets(sets)) ctrl_i (.*);

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model import cache_cfg_pkg::*, mem_bus_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_req_valid,
	input  logic              mem_req_write,
	input  logic [addr_w-1:0] mem_req_addr,
	input  word_t             mem_wdata,
	output logic              mem_ready,
	output logic              mem_rvalid,
	output word_t             mem_rdata
);

	localparam int depth = 8192; // 64 KiB of words

	word_t mem [depth];
	int wr_beats;
	int rd_beats;
	logic [addr_w-1:0] last_wr_addr;
	int cyc;
	int stall_cnt;
	int last_due;
	word_t data_q [$];
	int due_q [$];

	function automatic logic [31:0] scramble(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		logic [31:0] s;
		logic [31:0] hi;
		s = 32'h2884;
		for (int i = 0; i < depth; i++) begin
			s = scramble(s);
			hi = s;
			s = scramble(s);
			mem[i] = {hi, s} ^ {32'(i), 32'(i << 3)}; // mix in the word address
		end
	end

	assign mem_ready = (stall_cnt != 2); // every third request cycle stalls

	always @(posedge clk) begin
		if (!rst_n) begin
			cyc = 0;
			stall_cnt <= 0;
			last_due = 0;
			wr_beats = 0;
			rd_beats = 0;
			last_wr_addr = '0;
			data_q.delete();
			due_q.delete();
			mem_rvalid <= 1'b0;
			mem_rdata <= '0;
		end else begin
			cyc = cyc + 1;
			if (mem_req_valid && mem_ready) begin
				if (mem_req_write) begin
					mem[mem_req_addr[15:3]] = mem_wdata;
					last_wr_addr = mem_req_addr;
					wr_beats = wr_beats + 1;
				end else begin
					// 1 to 3 cycles, never ahead of an older beat
					last_due = (cyc + 1 + (rd_beats % 3) > last_due) ?
						cyc + 1 + (rd_beats % 3) : last_due + 1;
					data_q.push_back(mem[mem_req_addr[15:3]]);
					due_q.push_back(last_due);
					rd_beats = rd_beats + 1;
				end
			end
			if (mem_req_valid)
				stall_cnt <= (stall_cnt == 2) ? 0 : stall_cnt + 1;
			mem_rvalid <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				mem_rvalid <= 1'b1;
				mem_rdata <= data_q.pop_front();
				void'(due_q.pop_front());
			end
		end
	end

endmodule

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

	localparam int wait_limit = 200;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_write;
	logic [63:0] req_addr;
	logic [63:0] req_wdata;
	logic [7:0] req_wmask;
	logic req_ready;
	logic [63:0] rsp_rdata;
	logic mem_req_valid;
	logic mem_req_write;
	logic [63:0] mem_req_addr;
	logic [63:0] mem_wdata;
	logic mem_ready;
	logic mem_rvalid;
	logic [63:0] mem_rdata;

	logic [63:0] shadow [8192];
	int errors;
	int timeouts;
	logic [31:0] rng;

	dcache_top #(.sets(64)) dcache_top_i (.*);

	tb_mem_model mem_i (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic void check(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (exp === act) else begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endfunction

	task automatic access(input string name, input logic wr, input logic [63:0] addr,
			input logic [63:0] wdata, input logic [7:0] wmask,
			output logic [63:0] rdata, output int cycles);
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		rdata = '0;
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= wr;
		req_addr <= addr;
		req_wdata <= wdata;
		req_wmask <= wmask;
		while (!done && n < wait_limit) begin
			@(negedge clk);
			n++;
			if (req_ready) begin
				done = 1'b1;
				rdata = rsp_rdata;
			end
		end
		cycles = n;
		@(posedge clk);
		req_valid <= 1'b0;
		req_write <= 1'b0;
		if (!done) begin
			$display("timeout in %s: no req_ready for address %h", name, addr);
			timeouts++;
		end else if (wr) begin
			for (int b = 0; b < 8; b++)
				if (wmask[b])
					shadow[addr[15:3]][b*8 +: 8] = wdata[b*8 +: 8];
		end
	endtask

	task automatic load_check(input string name, input logic [63:0] addr, output int cycles);
		logic [63:0] d;
		access(name, 1'b0, addr, '0, '0, d, cycles);
		check(name, shadow[addr[15:3]], d);
	endtask

	task automatic store(input string name, input logic [63:0] addr, input logic [63:0] wdata,
			input logic [7:0] wmask);
		logic [63:0] d;
		int c;
		access(name, 1'b1, addr, wdata, wmask, d, c);
	endtask

	task automatic idle_after_reset();
		repeat (8) begin
			@(negedge clk);
			check("reset_idle", 64'd0, 64'(req_ready));
			check("reset_idle", 64'd0, 64'(mem_req_valid));
		end
	endtask

	task automatic load_miss_then_hits();
		int rd0;
		int wr0;
		int c;
		rd0 = mem_i.rd_beats;
		load_check("load_miss", 64'h1010, c);
		check("load_miss_beats", 64'd4, 64'(mem_i.rd_beats - rd0));
		rd0 = mem_i.rd_beats;
		wr0 = mem_i.wr_beats;
		for (int w = 0; w < 4; w++) begin
			load_check("load_hit", 64'h1000 + 64'(w * 8), c);
			check("load_hit_latency", 64'd2, 64'(c)); // ready one cycle after acceptance
		end
		check("load_hit_beats", 64'(rd0), 64'(mem_i.rd_beats));
		check("load_hit_beats", 64'(wr0), 64'(mem_i.wr_beats));
	endtask

	task automatic partial_store();
		int c;
		store("partial_store", 64'h1008, 64'h1122_3344_5566_7788, 8'h0f);
		load_check("partial_store", 64'h1008, c);
		check("partial_store_latency", 64'd2, 64'(c));
	endtask

	task automatic lru_eviction();
		logic [63:0] line [4];
		int c;
		int wr0;
		for (int i = 0; i < 4; i++)
			line[i] = 64'h2040 + 64'(i * 'h800); // all in set 2
		load_check("lru_fill0", line[0], c);
		load_check("lru_fill1", line[1], c);
		wr0 = mem_i.wr_beats;
		store("lru_dirty", line[0] + 16, 64'hdead_beef_0bad_f00d, 8'hff); // hit, line 1 now LRU
		load_check("lru_fill2", line[2] + 8, c); // evicts clean line 1
		check("lru_clean_wb", 64'(wr0), 64'(mem_i.wr_beats));
		load_check("lru_evict_dirty", line[3], c);
		check("lru_dirty_wb", 64'(wr0 + 4), 64'(mem_i.wr_beats));
		check("lru_dirty_addr", line[0] + 24, mem_i.last_wr_addr);
		load_check("lru_reload", line[0] + 16, c);
	endtask

	task automatic random_run();
		logic [63:0] addr;
		logic [63:0] wdata;
		logic [31:0] r;
		int c;
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			addr = 64'h4000 + 64'(r[3:2]) * 64'h800 + 64'(r[5:4]) * 32 + 64'(r[7:6]) * 8;
			if (r[8]) begin
				wdata = {next_rand(), next_rand()};
				store("random_store", addr, wdata, r[23:16]);
			end else begin
				load_check("random_load", addr, c);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_wmask = '0;
		errors = 0;
		timeouts = 0;
		rng = 32'h2884;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 8192; i++)
			shadow[i] = mem_i.mem[i]; // model contents before any write-back
		idle_after_reset();
		load_miss_then_hits();
		partial_store();
		lru_eviction();
		random_run();
		$display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dcache_sub.f ====
common/cache_cfg_pkg.sv
common/mem_bus_pkg.sv
dcache/cache_way.sv
dcache/dcache_ctrl.sv
verilog/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dcache -f dcache_sub.f -o sim_tb \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "no result in sim.log"; exit 1; }
